//--- common/bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// depth of the agent RAM in 32-bit words
`define BRIDGE_RAM_WORDS 256

// worst case waitrequest cycles for one access
`define BRIDGE_MAX_WAIT 3

// word index bits decoded by the RAM
`define BRIDGE_ADDR_BITS 8

// first fetch address after reset, inside the RAM window
`define BRIDGE_RESET_ADDR 32'h0000_0200

`endif

//--- common/avalon_pkg.sv
`default_nettype none

package avalon_pkg;

  // data path width of the Avalon-MM bus
  localparam int BUS_DATA_W = 32;
  localparam int BUS_BYTES  = BUS_DATA_W / 8;

  // one Avalon data word
  typedef logic [BUS_DATA_W-1:0] bus_word_t;

  // one enable bit per byte lane
  typedef logic [BUS_BYTES-1:0] byte_en_t;

  // all lanes on, used for fetches and aligned words
  localparam byte_en_t BE_FULL = '1;

endpackage

`default_nettype wire

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

  // byte offset inside a 32-bit word
  typedef logic [1:0] byte_off_t;

  // word index above the offset
  typedef logic [29:0] word_idx_t;

  typedef struct packed {
    word_idx_t word_idx;
    byte_off_t offset;
  } addr_fields_t;

  // core byte address, seen as raw word or as index plus offset
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t f;
  } cpu_addr_t;

  // one processor step on the bus
  typedef enum logic [2:0] {
    idle        = 3'd0,
    data_access = 3'd1,
    instr_set   = 3'd2, // turnaround between data and fetch
    instr_fetch = 3'd3,
    step_done   = 3'd4
  } seq_state_t;

endpackage

`default_nettype wire

//--- common/avalon_if.sv
`timescale 1ns/1ps
`default_nettype none

interface avalon_if import avalon_pkg::*, core_pkg::*;;

  cpu_addr_t address;
  logic      read;
  logic      write;
  bus_word_t writedata;
  byte_en_t  byteenable;
  bus_word_t readdata;    // valid when waitrequest is low
  logic      waitrequest; // request held while high

  modport host (
    output address, read, write, writedata, byteenable,
    input  readdata, waitrequest
  );

  modport agent (
    input  address, read, write, writedata, byteenable,
    output readdata, waitrequest
  );

endinterface

`default_nettype wire

//--- mem_bridge/lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module lane_align import avalon_pkg::*, core_pkg::*;
(
  input  byte_off_t offset,
  input  bus_word_t wdata_in,
  input  bus_word_t rdata_in,
  output byte_en_t  byte_en,
  output bus_word_t wdata_out,
  output bus_word_t rdata_out
);

  logic [4:0] shift_bits;

  // eight bits per byte of offset
  assign shift_bits = {offset, 3'b000};

  // lanes from the offset up to the top byte
  always_comb
  begin
    case (offset)
      2'd0:    byte_en = 4'b1111;
      2'd1:    byte_en = 4'b1110;
      2'd2:    byte_en = 4'b1100;
      default: byte_en = 4'b1000;
    endcase
  end

  // store data moves up into the addressed lanes
  assign wdata_out = wdata_in << shift_bits;

  // load data comes down to lane 0, zero fill on top
  assign rdata_out = rdata_in >> shift_bits;

endmodule

`default_nettype wire

//--- mem_bridge/mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge import avalon_pkg::*, core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  cpu_addr_t instr_address,
  input  cpu_addr_t data_address,
  input  logic      data_read,
  input  logic      data_write,
  input  bus_word_t data_writedata,
  output bus_word_t instr_readdata,
  output bus_word_t data_readdata,
  output logic      clk_enable,
  avalon_if.host    bus
);

  seq_state_t state;
  seq_state_t state_next;
  logic       data_req;
  logic       bus_done;
  byte_en_t   data_be;
  bus_word_t  data_wshift;
  bus_word_t  data_rshift;

  // a data access only when exactly one of read or write is asked for
  assign data_req = data_read ^ data_write;

  // completion of whatever request is on the bus this cycle
  assign bus_done = (bus.read | bus.write) & ~bus.waitrequest;

  lane_align u_lane (
    .offset    (data_address.f.offset),
    .wdata_in  (data_writedata),
    .rdata_in  (bus.readdata),
    .byte_en   (data_be),
    .wdata_out (data_wshift),
    .rdata_out (data_rshift)
  );

  always_comb
  begin
    state_next = state;
    case (state)
      idle:
      begin
        if (data_req)
          state_next = data_access;
        else
          state_next = instr_fetch; // no data, fetch only
      end
      data_access:
      begin
        if (bus_done)
          state_next = instr_set;
      end
      instr_set:   state_next = instr_fetch;
      instr_fetch:
      begin
        if (bus_done)
          state_next = step_done;
      end
      step_done:   state_next = idle;
      default:     state_next = idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= state_next;
  end

  // bus request mux, word aligned addresses only
  always_comb
  begin
    bus.address.f.word_idx = instr_address.f.word_idx;
    bus.address.f.offset   = '0;
    bus.read               = 1'b0;
    bus.write              = 1'b0;
    bus.writedata          = '0;
    bus.byteenable         = BE_FULL;
    case (state)
      data_access:
      begin
        bus.address.f.word_idx = data_address.f.word_idx;
        bus.read               = data_read;
        bus.write              = data_write;
        bus.writedata          = data_wshift;
        bus.byteenable         = data_be;
      end
      instr_fetch:
      begin
        bus.read = 1'b1; // fetch is always a full word
      end
      default:
      begin
        bus.read  = 1'b0;
        bus.write = 1'b0;
      end
    endcase
  end

  // read results held until the next completion
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      data_readdata  <= '0;
      instr_readdata <= '0;
    end
    else
    begin
      if (state == data_access && bus_done && data_read)
        data_readdata <= data_rshift;
      if (state == instr_fetch && bus_done)
        instr_readdata <= bus.readdata;
    end
  end

  // core runs one cycle per finished sequence
  assign clk_enable = (state == step_done);

endmodule

`default_nettype wire

//--- src/wait_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module wait_ram import avalon_pkg::*, core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  avalon_if.agent  bus
);

  localparam int WAIT_W = ($clog2(`BRIDGE_MAX_WAIT + 1) > 0) ?
                          $clog2(`BRIDGE_MAX_WAIT + 1) : 1;
  localparam logic [`BRIDGE_ADDR_BITS-1:0] LAST_IDX =
                          `BRIDGE_ADDR_BITS'(`BRIDGE_RAM_WORDS - 1);

  bus_word_t                    mem [`BRIDGE_RAM_WORDS];
  logic [`BRIDGE_ADDR_BITS-1:0] idx;
  logic [`BRIDGE_ADDR_BITS-1:0] clear_idx;
  logic                         clearing;
  logic                         in_access;
  logic [WAIT_W-1:0]            wait_cnt;
  logic [WAIT_W-1:0]            wait_load;
  logic                         req;
  logic                         done;

  assign idx = bus.address.f.word_idx[`BRIDGE_ADDR_BITS-1:0];
  assign req = bus.read | bus.write;

  // stall length depends on where the word sits
  assign wait_load = WAIT_W'(bus.address.f.word_idx % (`BRIDGE_MAX_WAIT + 1));

  // first cycle uses the fresh load, later ones the running count
  assign done = req & ~clearing & (in_access ? (wait_cnt == '0) : (wait_load == '0));

  assign bus.waitrequest = clearing | (req & ~done);
  assign bus.readdata    = mem[idx];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      clearing  <= 1'b1;
      clear_idx <= '0;
      in_access <= 1'b0;
      wait_cnt  <= '0;
    end
    else if (clearing)
    begin
      clear_idx <= clear_idx + 1'b1;
      if (clear_idx == LAST_IDX)
        clearing <= 1'b0; // sweep finished
    end
    else if (req && !done)
    begin
      if (in_access)
        wait_cnt <= wait_cnt - 1'b1;
      else
      begin
        in_access <= 1'b1;
        wait_cnt  <= wait_load - 1'b1;
      end
    end
    else if (done)
      in_access <= 1'b0; // reload on next request
  end

  // array write port, sweep first then byte lanes
  always_ff @(posedge clk)
  begin
    if (clearing)
      mem[clear_idx] <= '0;
    else if (done && bus.write)
    begin
      for (int b = 0; b < BUS_BYTES; b++)
      begin
        if (bus.byteenable[b])
          mem[idx][8*b +: 8] <= bus.writedata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_top
(
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] instr_address,
  input  logic [31:0] data_address,
  input  logic        data_read,
  input  logic        data_write,
  input  logic [31:0] data_writedata,
  output logic [31:0] instr_readdata,
  output logic [31:0] data_readdata,
  output logic        clk_enable
);

  // single shared Avalon bus
  avalon_if bus0 ();

  mem_bridge u_bridge (
    .clk            (clk),
    .rst            (rst),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_read      (data_read),
    .data_write     (data_write),
    .data_writedata (data_writedata),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata),
    .clk_enable     (clk_enable),
    .bus            (bus0.host)
  );

  // memory with address dependent stalls
  wait_ram u_ram (
    .clk (clk),
    .rst (rst),
    .bus (bus0.agent)
  );

endmodule

`default_nettype wire

//--- tests/tb_bridge_table.svh
`ifndef TB_BRIDGE_TABLE_SVH
`define TB_BRIDGE_TABLE_SVH

// columns: row, instr byte address, data byte address, data_read, data_write
// write data comes from the xorshift stream, expected words from the memory model
localparam int NUM_ROWS = 21;

task automatic load_table();
  // full word at index 16, then read it back
  set_row(0,  32'h0000_0040, 32'h0000_0040, 1'b0, 1'b1);
  set_row(1,  32'h0000_0044, 32'h0000_0040, 1'b1, 1'b0);
  // index 19 has three wait states
  set_row(2,  32'h0000_0048, 32'h0000_004c, 1'b0, 1'b1);
  set_row(3,  32'h0000_004c, 32'h0000_004d, 1'b0, 1'b1); // offset 1
  set_row(4,  32'h0000_004c, 32'h0000_004e, 1'b0, 1'b1); // offset 2
  set_row(5,  32'h0000_004c, 32'h0000_004f, 1'b0, 1'b1); // offset 3
  // merged word, then the shifted views
  set_row(6,  32'h0000_0040, 32'h0000_004c, 1'b1, 1'b0);
  set_row(7,  32'h0000_0048, 32'h0000_004d, 1'b1, 1'b0);
  set_row(8,  32'h0000_0048, 32'h0000_004e, 1'b1, 1'b0);
  set_row(9,  32'h0000_0048, 32'h0000_004f, 1'b1, 1'b0);
  // fetch only, neither and both flags
  set_row(10, 32'h0000_004c, 32'h0000_0044, 1'b0, 1'b0);
  set_row(11, 32'h0000_0040, 32'h0000_0044, 1'b1, 1'b1);
  // index 37 and the top word of the RAM
  set_row(12, 32'h0000_0094, 32'h0000_0094, 1'b0, 1'b1);
  set_row(13, 32'h0000_03fc, 32'h0000_03fe, 1'b0, 1'b1);
  set_row(14, 32'h0000_0094, 32'h0000_03fc, 1'b1, 1'b0);
  set_row(15, 32'h0000_03fc, 32'h0000_0095, 1'b1, 1'b0);
  // index 18, two wait states
  set_row(16, 32'h0000_0048, 32'h0000_0048, 1'b0, 1'b1);
  set_row(17, 32'h0000_0048, 32'h0000_0049, 1'b1, 1'b1); // both high
  set_row(18, 32'h0000_0200, 32'h0000_004a, 1'b1, 1'b0);
  // partial write into a cleared word
  set_row(19, 32'h0000_0044, 32'h0000_0051, 1'b0, 1'b1);
  set_row(20, 32'h0000_0050, 32'h0000_0050, 1'b1, 1'b0);
endtask

`endif

//--- tests/tb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module tb_bridge import avalon_pkg::*, core_pkg::*;;

  `include "tb_bridge_table.svh"

  // reset, RAM sweep, every row at worst case wait, plus slack
  localparam int CYCLE_LIMIT = 10 + `BRIDGE_RAM_WORDS +
                               (NUM_ROWS + 2) * (6 + 2 * `BRIDGE_MAX_WAIT) + 20;

  logic        clk;
  logic        rst;
  logic [31:0] instr_address;
  logic [31:0] data_address;
  logic        data_read;
  logic        data_write;
  logic [31:0] data_writedata;
  logic [31:0] instr_readdata;
  logic [31:0] data_readdata;
  logic        clk_enable;

  logic [31:0] row_iaddr [NUM_ROWS];
  logic [31:0] row_daddr [NUM_ROWS];
  logic        row_rd [NUM_ROWS];
  logic        row_wr [NUM_ROWS];
  bus_word_t   row_wdata [NUM_ROWS];
  bus_word_t   row_exp_data [NUM_ROWS];
  bus_word_t   row_exp_instr [NUM_ROWS];

  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  logic [31:0] rand_state;

  bridge_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_read      (data_read),
    .data_write     (data_write),
    .data_writedata (data_writedata),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata),
    .clk_enable     (clk_enable)
  );

  always #20 clk = ~clk;

  // watchdog
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      if (dut0.u_bridge.state == idle)
        $display("timeout after %0d cycles, bridge idle", cycle_count);
      else
        $display("timeout after %0d cycles, bridge stuck in state %0d", cycle_count,
                 dut0.u_bridge.state);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic set_row(input int r, input logic [31:0] iaddr, input logic [31:0] daddr,
                         input logic rd, input logic wr);
    row_iaddr[r] = iaddr;
    row_daddr[r] = daddr;
    row_rd[r]    = rd;
    row_wr[r]    = wr;
  endtask

  task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // memory model, byte lanes worked out one at a time
  task automatic compute_expected();
    bus_word_t model_mem [`BRIDGE_RAM_WORDS];
    bus_word_t last_data;
    int        widx;
    int        off;
    int        b;
    last_data = '0; // data register after reset
    for (int i = 0; i < `BRIDGE_RAM_WORDS; i++)
      model_mem[i] = '0;
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      widx = (row_daddr[r] >> 2) % `BRIDGE_RAM_WORDS;
      off  = row_daddr[r] % 4;
      if (row_wr[r] && !row_rd[r])
      begin
        for (b = off; b < 4; b++)
          model_mem[widx][8*b +: 8] = row_wdata[r][8*(b-off) +: 8];
      end
      if (row_rd[r] && !row_wr[r])
      begin
        last_data = '0;
        for (b = 0; b < 4 - off; b++)
          last_data[8*b +: 8] = model_mem[widx][8*(b+off) +: 8];
      end
      row_exp_data[r]  = last_data;
      row_exp_instr[r] = model_mem[(row_iaddr[r] >> 2) % `BRIDGE_RAM_WORDS];
    end
  endtask

  // outputs stay quiet until the reset fetch finishes
  task automatic wait_reset_step();
    bit seen;
    int samples;
    int errs_before;
    seen        = 0;
    samples     = 0;
    errs_before = error_count;
    while (!seen)
    begin
      @(negedge clk);
      if (samples < `BRIDGE_RAM_WORDS)
        check_flag("clk_enable", clk_enable, 1'b0); // fetch waits for the RAM sweep
      if (clk_enable)
        seen = 1;
      check_word("data_readdata", data_readdata, '0);
      check_word("instr_readdata", instr_readdata, '0); // RAM is cleared
      samples++;
    end
    $display("reset step: %0d cycles, %0d errors", cycle_count, error_count - errs_before);
  endtask

  task automatic run_row(input int r);
    bit    seen;
    int    pulses;
    int    samples;
    int    errs_before;
    string kind;
    @(posedge clk);
    #2;
    instr_address  = row_iaddr[r];
    data_address   = row_daddr[r];
    data_read      = row_rd[r];
    data_write     = row_wr[r];
    data_writedata = row_wdata[r];
    errs_before    = error_count;
    seen           = 0;
    pulses         = 0;
    samples        = 0;
    while (!seen)
    begin
      @(negedge clk);
      if (samples == 0)
        check_flag("clk_enable", clk_enable, 1'b0); // idle cycle
      if (clk_enable)
      begin
        pulses++;
        if (samples > 0)
          seen = 1;
      end
      samples++;
    end
    if (pulses != 1)
    begin
      error_count++;
      $display("row %0d saw %0d clk_enable pulses instead of one", r, pulses);
    end
    check_word("data_readdata", data_readdata, row_exp_data[r]);
    check_word("instr_readdata", instr_readdata, row_exp_instr[r]);
    if (row_rd[r] ^ row_wr[r])
      kind = row_wr[r] ? "write" : "read";
    else
      kind = "fetch only";
    $display("row %0d: %s at %h, %0d cycles, %0d errors", r, kind, row_daddr[r], samples,
             error_count - errs_before);
  endtask

  initial
  begin
    clk            = 1'b0;
    rst            = 1'b1;
    instr_address  = `BRIDGE_RESET_ADDR;
    data_address   = '0;
    data_read      = 1'b0;
    data_write     = 1'b0;
    data_writedata = '0;
    rand_state     = 32'h0b0a6353;

    load_table();
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      rand_state   = next_random(rand_state);
      row_wdata[r] = rand_state;
    end
    compute_expected();

    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    wait_reset_step();

    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);

    // last pulse must drop after one cycle
    @(posedge clk);
    #2;
    data_read  = 1'b0;
    data_write = 1'b0;
    @(negedge clk);
    check_flag("clk_enable", clk_enable, 1'b0);

    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, check_count, error_count);
    if (error_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- membridge.f
+incdir+common
+incdir+tests
common/avalon_pkg.sv
common/core_pkg.sv
common/avalon_if.sv
mem_bridge/lane_align.sv
mem_bridge/mem_bridge.sv
src/wait_ram.sv
src/bridge_top.sv
tests/tb_bridge.sv
